// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== core_top.sv ====
`timescale 1ns/100ps

module core_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    input  logic [31:0] inst,
    input  logic        valid,
    input  logic        fetch_exc,
    input  logic [6:0]  fetch_cause,
    output logic        commit_valid,
    output logic [31:0] commit_pc,
    output logic        commit_we,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    output logic        commit_exc,
    output logic [6:0]  commit_cause
);
    logic [7:0]  aluop;
    logic [2:0]  alusel;
    logic [31:0] imm;
    logic        reg1_read_en;
    logic        reg2_read_en;
    logic [4:0]  reg1_addr;
    logic [4:0]  reg2_addr;
    logic [4:0]  rd;
    logic        reg_write_en;
    logic        exc;
    logic [6:0]  exc_cause;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic [31:0] ex_result;
    logic        ex_we;
    logic [4:0]  ex_rd;
    logic        ex_exc;
    logic [6:0]  ex_cause;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    inst_decode u_inst_decode (
        .inst(inst), .fetch_exc(fetch_exc), .fetch_cause(fetch_cause),
        .aluop(aluop), .alusel(alusel), .imm(imm),
        .reg1_read_en(reg1_read_en), .reg2_read_en(reg2_read_en),
        .reg1_addr(reg1_addr), .reg2_addr(reg2_addr), .rd(rd),
        .reg_write_en(reg_write_en), .exc(exc), .exc_cause(exc_cause)
    );

    reg_file u_reg_file (
        .clk(clk), .rst(rst),
        .re1(reg1_read_en), .raddr1(reg1_addr), .rdata1(rdata1),
        .re2(reg2_read_en), .raddr2(reg2_addr), .rdata2(rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    exec_alu u_exec_alu (
        .clk(clk), .rst(rst), .valid(valid), .pc(pc),
        .aluop(aluop), .alusel(alusel), .imm(imm),
        .rdata1(rdata1), .rdata2(rdata2), .reg2_read_en(reg2_read_en),
        .reg_write_en(reg_write_en), .rd(rd), .exc(exc), .exc_cause(exc_cause),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_result(ex_result), .ex_we(ex_we),
        .ex_rd(ex_rd), .ex_exc(ex_exc), .ex_cause(ex_cause)
    );

    result_commit u_result_commit (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_pc(ex_pc), .ex_result(ex_result), .ex_we(ex_we),
        .ex_rd(ex_rd), .ex_exc(ex_exc), .ex_cause(ex_cause),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_we(commit_we),
        .commit_rd(commit_rd), .commit_data(commit_data),
        .commit_exc(commit_exc), .commit_cause(commit_cause)
    );

endmodule

// ==== decode_1ri20.sv ====
`timescale 1ns/100ps

module decode_1ri20 (
    input  la_pkg::inst_t inst,
    output logic          match,
    output logic [7:0]    aluop,
    output logic [2:0]    alusel,
    output logic [31:0]   imm,
    output logic          reg1_read_en,
    output logic          reg2_read_en,
    output logic [4:0]    reg1_addr,
    output logic [4:0]    reg2_addr,
    output logic [4:0]    rd,
    output logic          reg_write_en
);

    assign match = (inst[31:25] == la_pkg::OPC_LU12I);

    assign aluop  = match ? la_pkg::ALU_LUI : la_pkg::ALU_NOP;
    assign alusel = match ? la_pkg::SEL_ARITH : la_pkg::SEL_NOP;
    assign imm    = match ? {inst[24:5], 12'd0} : 32'd0; // si20 << 12

    assign reg1_read_en = 1'b0;
    assign reg2_read_en = 1'b0;
    assign reg1_addr    = 5'd0;
    assign reg2_addr    = 5'd0;
    assign reg_write_en = match;
    assign rd           = match ? inst.i12.rd : 5'd0;

endmodule

// ==== decode_2ri12.sv ====
`timescale 1ns/100ps

module decode_2ri12 (
    input  la_pkg::inst_t inst,
    output logic          match,
    output logic [7:0]    aluop,
    output logic [2:0]    alusel,
    output logic [31:0]   imm,
    output logic          reg1_read_en,
    output logic          reg2_read_en,
    output logic [4:0]    reg1_addr,
    output logic [4:0]    reg2_addr,
    output logic [4:0]    rd,
    output logic          reg_write_en
);
    logic sext; // si12 vs ui12

    always_comb begin
        match  = 1'b1;
        sext   = 1'b1;
        aluop  = la_pkg::ALU_NOP;
        alusel = la_pkg::SEL_ARITH;
        case (inst.i12.opcode)
            la_pkg::OPC12_ADDI:  aluop = la_pkg::ALU_ADD;
            la_pkg::OPC12_SLTI:  aluop = la_pkg::ALU_SLT;
            la_pkg::OPC12_SLTUI: aluop = la_pkg::ALU_SLTU;
            la_pkg::OPC12_ANDI: begin
                aluop  = la_pkg::ALU_AND;
                alusel = la_pkg::SEL_LOGIC;
                sext   = 1'b0;
            end
            la_pkg::OPC12_ORI: begin
                aluop  = la_pkg::ALU_OR;
                alusel = la_pkg::SEL_LOGIC;
                sext   = 1'b0;
            end
            la_pkg::OPC12_XORI: begin
                aluop  = la_pkg::ALU_XOR;
                alusel = la_pkg::SEL_LOGIC;
                sext   = 1'b0;
            end
            default: begin
                match  = 1'b0;
                alusel = la_pkg::SEL_NOP;
            end
        endcase
    end

    assign imm = !match ? 32'd0 :
                 sext   ? {{20{inst.i12.imm12[11]}}, inst.i12.imm12} :
                          {20'd0, inst.i12.imm12};

    assign reg1_read_en = match;
    assign reg2_read_en = 1'b0; // second operand is imm
    assign reg_write_en = match;
    assign reg1_addr    = match ? inst.i12.rj : 5'd0;
    assign reg2_addr    = 5'd0;
    assign rd           = match ? inst.i12.rd : 5'd0;

endmodule

// ==== decode_3r.sv ====
`timescale 1ns/100ps

module decode_3r (
    input  la_pkg::inst_t inst,
    output logic          match,
    output logic [7:0]    aluop,
    output logic [2:0]    alusel,
    output logic [31:0]   imm,
    output logic          reg1_read_en,
    output logic          reg2_read_en,
    output logic [4:0]    reg1_addr,
    output logic [4:0]    reg2_addr,
    output logic [4:0]    rd,
    output logic          reg_write_en
);
    logic trap; // syscall or break

    always_comb begin
        match  = 1'b1;
        aluop  = la_pkg::ALU_NOP;
        alusel = la_pkg::SEL_ARITH;
        case (inst.r3.opcode)
            la_pkg::OPC3R_ADD:  aluop = la_pkg::ALU_ADD;
            la_pkg::OPC3R_SUB:  aluop = la_pkg::ALU_SUB;
            la_pkg::OPC3R_SLT:  aluop = la_pkg::ALU_SLT;
            la_pkg::OPC3R_SLTU: aluop = la_pkg::ALU_SLTU;
            la_pkg::OPC3R_AND: begin
                aluop  = la_pkg::ALU_AND;
                alusel = la_pkg::SEL_LOGIC;
            end
            la_pkg::OPC3R_OR: begin
                aluop  = la_pkg::ALU_OR;
                alusel = la_pkg::SEL_LOGIC;
            end
            la_pkg::OPC3R_XOR: begin
                aluop  = la_pkg::ALU_XOR;
                alusel = la_pkg::SEL_LOGIC;
            end
            la_pkg::OPC3R_SYSCALL: begin
                aluop  = la_pkg::ALU_SYSCALL;
                alusel = la_pkg::SEL_NOP;
            end
            la_pkg::OPC3R_BREAK: begin
                aluop  = la_pkg::ALU_BREAK;
                alusel = la_pkg::SEL_NOP;
            end
            default: begin
                match  = 1'b0;
                alusel = la_pkg::SEL_NOP;
            end
        endcase
    end

    assign trap         = (aluop == la_pkg::ALU_SYSCALL) || (aluop == la_pkg::ALU_BREAK);
    assign reg1_read_en = match & ~trap;
    assign reg2_read_en = match & ~trap;
    assign reg_write_en = match & ~trap;
    assign reg1_addr    = reg1_read_en ? inst.r3.rj : 5'd0;
    assign reg2_addr    = reg2_read_en ? inst.r3.rk : 5'd0;
    assign rd           = reg_write_en ? inst.r3.rd : 5'd0; // code field ignored
    assign imm          = 32'd0;

endmodule

// ==== exec_alu.sv ====
`timescale 1ns/100ps

module exec_alu (
    input  logic        clk,
    input  logic        rst,
    input  logic        valid,
    input  logic [31:0] pc,
    input  logic [7:0]  aluop,
    input  logic [2:0]  alusel,
    input  logic [31:0] imm,
    input  logic [31:0] rdata1,
    input  logic [31:0] rdata2,
    input  logic        reg2_read_en,
    input  logic        reg_write_en,
    input  logic [4:0]  rd,
    input  logic        exc,
    input  logic [6:0]  exc_cause,
    output logic        ex_valid,
    output logic [31:0] ex_pc,
    output logic [31:0] ex_result,
    output logic        ex_we,
    output logic [4:0]  ex_rd,
    output logic        ex_exc,
    output logic [6:0]  ex_cause
);
    logic [31:0] src_b;
    logic [31:0] arith_res;
    logic [31:0] logic_res;
    logic [31:0] result;

    assign src_b = reg2_read_en ? rdata2 : imm; // imm already extended

    always_comb begin
        case (aluop)
            la_pkg::ALU_ADD:  arith_res = rdata1 + src_b;
            la_pkg::ALU_SUB:  arith_res = rdata1 - src_b;
            la_pkg::ALU_SLT:  arith_res = {31'd0, $signed(rdata1) < $signed(src_b)};
            la_pkg::ALU_SLTU: arith_res = {31'd0, rdata1 < src_b};
            la_pkg::ALU_LUI:  arith_res = src_b;
            default:          arith_res = 32'd0;
        endcase
    end

    always_comb begin
        case (aluop)
            la_pkg::ALU_AND: logic_res = rdata1 & src_b;
            la_pkg::ALU_OR:  logic_res = rdata1 | src_b;
            la_pkg::ALU_XOR: logic_res = rdata1 ^ src_b;
            default:         logic_res = 32'd0;
        endcase
    end

    always_comb begin
        case (alusel)
            la_pkg::SEL_ARITH: result = arith_res;
            la_pkg::SEL_LOGIC: result = logic_res;
            default:           result = 32'd0; // traps carry no result
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_we    <= 1'b0;
            ex_exc   <= 1'b0;
        end else begin
            ex_valid <= valid;
            ex_we    <= reg_write_en;
            ex_exc   <= exc;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc     <= pc;
        ex_result <= result;
        ex_rd     <= rd;
        ex_cause  <= exc_cause;
    end

endmodule

// ==== inst_decode.sv ====
`timescale 1ns/100ps

module inst_decode (
    input  la_pkg::inst_t inst,
    input  logic          fetch_exc,
    input  logic [6:0]    fetch_cause,
    output logic [7:0]    aluop,
    output logic [2:0]    alusel,
    output logic [31:0]   imm,
    output logic          reg1_read_en,
    output logic          reg2_read_en,
    output logic [4:0]    reg1_addr,
    output logic [4:0]    reg2_addr,
    output logic [4:0]    rd,
    output logic          reg_write_en,
    output logic          exc,
    output logic [6:0]    exc_cause
);
    // index 0 is 3R, 1 is 2RI12, 2 is 1RI20
    logic [2:0]  match_vec;
    logic [7:0]  d_aluop [3];
    logic [2:0]  d_alusel [3];
    logic [31:0] d_imm [3];
    logic [2:0]  d_re1;
    logic [2:0]  d_re2;
    logic [4:0]  d_raddr1 [3];
    logic [4:0]  d_raddr2 [3];
    logic [4:0]  d_rd [3];
    logic [2:0]  d_we;
    logic [1:0]  sel;
    logic        one_hot;

    decode_3r u_decode_3r (
        .inst(inst), .match(match_vec[0]), .aluop(d_aluop[0]), .alusel(d_alusel[0]),
        .imm(d_imm[0]), .reg1_read_en(d_re1[0]), .reg2_read_en(d_re2[0]),
        .reg1_addr(d_raddr1[0]), .reg2_addr(d_raddr2[0]), .rd(d_rd[0]),
        .reg_write_en(d_we[0])
    );

    decode_2ri12 u_decode_2ri12 (
        .inst(inst), .match(match_vec[1]), .aluop(d_aluop[1]), .alusel(d_alusel[1]),
        .imm(d_imm[1]), .reg1_read_en(d_re1[1]), .reg2_read_en(d_re2[1]),
        .reg1_addr(d_raddr1[1]), .reg2_addr(d_raddr2[1]), .rd(d_rd[1]),
        .reg_write_en(d_we[1])
    );

    decode_1ri20 u_decode_1ri20 (
        .inst(inst), .match(match_vec[2]), .aluop(d_aluop[2]), .alusel(d_alusel[2]),
        .imm(d_imm[2]), .reg1_read_en(d_re1[2]), .reg2_read_en(d_re2[2]),
        .reg1_addr(d_raddr1[2]), .reg2_addr(d_raddr2[2]), .rd(d_rd[2]),
        .reg_write_en(d_we[2])
    );

    always_comb begin
        one_hot = 1'b1;
        sel     = 2'd0;
        case (match_vec)
            3'b001:  sel = 2'd0;
            3'b010:  sel = 2'd1;
            3'b100:  sel = 2'd2;
            default: one_hot = 1'b0; // none or ambiguous
        endcase
    end

    assign aluop        = one_hot ? d_aluop[sel] : la_pkg::ALU_NOP;
    assign alusel       = one_hot ? d_alusel[sel] : la_pkg::SEL_NOP;
    assign imm          = one_hot ? d_imm[sel] : 32'd0;
    assign reg1_read_en = one_hot & d_re1[sel];
    assign reg2_read_en = one_hot & d_re2[sel];
    assign reg1_addr    = one_hot ? d_raddr1[sel] : 5'd0;
    assign reg2_addr    = one_hot ? d_raddr2[sel] : 5'd0;
    assign rd           = one_hot ? d_rd[sel] : 5'd0;
    assign reg_write_en = one_hot & d_we[sel];

    // fetch side wins over decode
    always_comb begin
        exc       = 1'b1;
        exc_cause = fetch_cause;
        if (!fetch_exc) begin
            if (!one_hot) begin
                exc_cause = la_pkg::EXC_INE;
            end else if (aluop == la_pkg::ALU_SYSCALL) begin
                exc_cause = la_pkg::EXC_SYS;
            end else if (aluop == la_pkg::ALU_BREAK) begin
                exc_cause = la_pkg::EXC_BRK;
            end else begin
                exc       = 1'b0;
                exc_cause = la_pkg::EXC_NONE;
            end
        end
    end

endmodule

// ==== la_pkg.sv ====
package la_pkg;

    // 3R view with opcode in [31:15]
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } r3_t;

    // 2RI12 view with opcode in [31:22]
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } i12_t;

    typedef union packed {
        r3_t  r3;
        i12_t i12;
    } inst_t;

    localparam logic [7:0] ALU_NOP     = 8'h00;
    localparam logic [7:0] ALU_ADD     = 8'h01;
    localparam logic [7:0] ALU_SUB     = 8'h02;
    localparam logic [7:0] ALU_SLT     = 8'h03;
    localparam logic [7:0] ALU_SLTU    = 8'h04;
    localparam logic [7:0] ALU_AND     = 8'h05;
    localparam logic [7:0] ALU_OR      = 8'h06;
    localparam logic [7:0] ALU_XOR     = 8'h07;
    localparam logic [7:0] ALU_LUI     = 8'h08; // pass immediate
    localparam logic [7:0] ALU_SYSCALL = 8'h10;
    localparam logic [7:0] ALU_BREAK   = 8'h11;

    localparam logic [2:0] SEL_NOP   = 3'd0;
    localparam logic [2:0] SEL_ARITH = 3'd1;
    localparam logic [2:0] SEL_LOGIC = 3'd2;

    localparam logic [6:0] EXC_NONE = 7'h00;
    localparam logic [6:0] EXC_SYS  = 7'h0b;
    localparam logic [6:0] EXC_BRK  = 7'h0c;
    localparam logic [6:0] EXC_INE  = 7'h0d;

    localparam logic [16:0] OPC3R_ADD     = 17'h00020;
    localparam logic [16:0] OPC3R_SUB     = 17'h00022;
    localparam logic [16:0] OPC3R_SLT     = 17'h00024;
    localparam logic [16:0] OPC3R_SLTU    = 17'h00025;
    localparam logic [16:0] OPC3R_AND     = 17'h00029;
    localparam logic [16:0] OPC3R_OR      = 17'h0002a;
    localparam logic [16:0] OPC3R_XOR     = 17'h0002b;
    localparam logic [16:0] OPC3R_BREAK   = 17'h00054;
    localparam logic [16:0] OPC3R_SYSCALL = 17'h00056;

    localparam logic [9:0] OPC12_SLTI  = 10'h008;
    localparam logic [9:0] OPC12_SLTUI = 10'h009;
    localparam logic [9:0] OPC12_ADDI  = 10'h00a;
    localparam logic [9:0] OPC12_ANDI  = 10'h00d;
    localparam logic [9:0] OPC12_ORI   = 10'h00e;
    localparam logic [9:0] OPC12_XORI  = 10'h00f;

    localparam logic [6:0] OPC_LU12I = 7'h0a;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic        re1,
    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic        re2,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so a same-cycle reader sees the new value
    always_comb begin
        if (!re1 || raddr1 == 5'd0)
            rdata1 = 32'd0;
        else if (we && waddr == raddr1)
            rdata1 = wdata;
        else
            rdata1 = regs[raddr1];
    end

    always_comb begin
        if (!re2 || raddr2 == 5'd0)
            rdata2 = 32'd0;
        else if (we && waddr == raddr2)
            rdata2 = wdata;
        else
            rdata2 = regs[raddr2];
    end

endmodule

// ==== result_commit.sv ====
`timescale 1ns/100ps

module result_commit (
    input  logic        clk,
    input  logic        rst,
    input  logic        ex_valid,
    input  logic [31:0] ex_pc,
    input  logic [31:0] ex_result,
    input  logic        ex_we,
    input  logic [4:0]  ex_rd,
    input  logic        ex_exc,
    input  logic [6:0]  ex_cause,
    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,
    output logic        commit_valid,
    output logic [31:0] commit_pc,
    output logic        commit_we,
    output logic [4:0]  commit_rd,
    output logic [31:0] commit_data,
    output logic        commit_exc,
    output logic [6:0]  commit_cause
);

    // the only place a write is allowed through
    assign rf_we    = ex_valid & ~ex_exc & ex_we & (ex_rd != 5'd0);
    assign rf_waddr = ex_rd;
    assign rf_wdata = ex_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_valid <= 1'b0;
            commit_we    <= 1'b0;
            commit_exc   <= 1'b0;
        end else begin
            commit_valid <= ex_valid;
            commit_we    <= rf_we;
            commit_exc   <= ex_valid & ex_exc; // exc is only meaningful with valid
        end
    end

    always_ff @(posedge clk) begin
        commit_pc    <= ex_pc;
        commit_rd    <= ex_rd;
        commit_data  <= ex_result;
        commit_cause <= ex_cause;
    end

endmodule

// ==== tb.f ====
la_pkg.sv
decode_3r.sv
decode_2ri12.sv
decode_1ri20.sv
inst_decode.sv
reg_file.sv
exec_alu.sv
result_commit.sv
core_top.sv
tb_core.sv

// ==== tb_core.sv ====
`timescale 1ns/100ps

module tb_core;

    logic        clk;
    logic        rst;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        valid;
    logic        fetch_exc;
    logic [6:0]  fetch_cause;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_we;
    logic [4:0]  commit_rd;
    logic [31:0] commit_data;
    logic        commit_exc;
    logic [6:0]  commit_cause;

    logic [31:0] ref_regs [32]; // architectural state of the model
    logic [31:0] q_pc [$];
    logic [31:0] q_data [$];
    logic [4:0]  q_rd [$];
    logic        q_we [$];
    logic        q_exc [$];
    logic [6:0]  q_cause [$];
    logic [15:0] lfsr;
    logic [31:0] next_pc;
    logic        v_d1;
    logic        v_d2;
    string       test_name;

    core_top UUT (
        .clk(clk), .rst(rst), .pc(pc), .inst(inst), .valid(valid),
        .fetch_exc(fetch_exc), .fetch_cause(fetch_cause),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_we(commit_we),
        .commit_rd(commit_rd), .commit_data(commit_data),
        .commit_exc(commit_exc), .commit_cause(commit_cause)
    );

    always #10 clk = ~clk;

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string field, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("** Error %s %s expected 0x%08h actual 0x%08h", test_name, field, exp, act);
        abort_run();
    endtask

    task automatic report_problem(input string msg);
        $display("%s (test %s)", msg, test_name);
        abort_run();
    endtask

    // x^16 + x^14 + x^13 + x^11
    function automatic logic next_bit();
        logic fb;
        fb       = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        next_bit = lfsr[15];
        lfsr     = {lfsr[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        logic [31:0] e_pc;
        logic [31:0] e_data;
        logic [4:0]  e_rd;
        logic        e_we;
        logic        e_exc;
        logic [6:0]  e_cause;
        if (rst) begin
            v_d1 = 1'b0;
            v_d2 = 1'b0;
        end else begin
            ck_latency: assert (commit_valid === v_d2)
                else report_mismatch("commit_valid", 32'(v_d2), 32'(commit_valid));
            v_d2 = v_d1;
            v_d1 = valid;
            if (commit_valid === 1'b1) begin
                if (q_pc.size() == 0) begin
                    report_problem("commit seen with no instruction outstanding");
                end else begin
                    e_pc    = q_pc.pop_front();
                    e_data  = q_data.pop_front();
                    e_rd    = q_rd.pop_front();
                    e_we    = q_we.pop_front();
                    e_exc   = q_exc.pop_front();
                    e_cause = q_cause.pop_front();
                    ck_pc: assert (commit_pc === e_pc)
                        else report_mismatch("commit_pc", e_pc, commit_pc);
                    ck_exc: assert (commit_exc === e_exc)
                        else report_mismatch("commit_exc", 32'(e_exc), 32'(commit_exc));
                    ck_cause: assert (commit_cause === e_cause)
                        else report_mismatch("commit_cause", 32'(e_cause), 32'(commit_cause));
                    ck_we: assert (commit_we === e_we)
                        else report_mismatch("commit_we", 32'(e_we), 32'(commit_we));
                    if (!e_exc) begin
                        ck_rd: assert (commit_rd === e_rd)
                            else report_mismatch("commit_rd", 32'(e_rd), 32'(commit_rd));
                        ck_data: assert (commit_data === e_data)
                            else report_mismatch("commit_data", e_data, commit_data);
                    end
                end
            end
        end
    end

    task automatic check_idle();
        ck_idle_valid: assert (commit_valid === 1'b0)
            else report_mismatch("commit_valid", 32'd0, 32'(commit_valid));
        ck_idle_we: assert (commit_we === 1'b0)
            else report_mismatch("commit_we", 32'd0, 32'(commit_we));
        ck_idle_exc: assert (commit_exc === 1'b0)
            else report_mismatch("commit_exc", 32'd0, 32'(commit_exc));
    endtask

    task automatic issue(input logic [31:0] word, input logic fexc, input logic [6:0] fcause,
                         input logic exp_exc, input logic [6:0] exp_cause,
                         input logic [4:0] exp_rd, input logic [31:0] exp_data);
        @(posedge clk);
        inst        <= word;
        pc          <= next_pc;
        valid       <= 1'b1;
        fetch_exc   <= fexc;
        fetch_cause <= fcause;
        q_pc.push_back(next_pc);
        q_data.push_back(exp_data);
        q_rd.push_back(exp_rd);
        q_we.push_back(!exp_exc && exp_rd != 5'd0);
        q_exc.push_back(exp_exc);
        q_cause.push_back(exp_cause);
        if (!exp_exc && exp_rd != 5'd0)
            ref_regs[exp_rd] = exp_data;
        next_pc = next_pc + 32'd4;
    endtask

    task automatic run_3r(input logic [16:0] opc, input logic [4:0] rd, input logic [4:0] rj,
                          input logic [4:0] rk);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        a = ref_regs[rj];
        b = ref_regs[rk];
        case (opc)
            la_pkg::OPC3R_ADD:  r = a + b;
            la_pkg::OPC3R_SUB:  r = a - b;
            la_pkg::OPC3R_SLT:  r = {31'd0, $signed(a) < $signed(b)};
            la_pkg::OPC3R_SLTU: r = {31'd0, a < b};
            la_pkg::OPC3R_AND:  r = a & b;
            la_pkg::OPC3R_OR:   r = a | b;
            default:            r = a ^ b;
        endcase
        // cause ignored without fetch_exc
        issue({opc, rk, rj, rd}, 1'b0, 7'h7f, 1'b0, la_pkg::EXC_NONE, rd, r);
    endtask

    task automatic run_i12(input logic [9:0] opc, input logic [4:0] rd, input logic [4:0] rj,
                           input logic [11:0] imm12);
        logic [31:0] a;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] r;
        a  = ref_regs[rj];
        sx = {{20{imm12[11]}}, imm12};
        zx = {20'd0, imm12};
        case (opc)
            la_pkg::OPC12_ADDI:  r = a + sx;
            la_pkg::OPC12_SLTI:  r = {31'd0, $signed(a) < $signed(sx)};
            la_pkg::OPC12_SLTUI: r = {31'd0, a < sx};
            la_pkg::OPC12_ANDI:  r = a & zx;
            la_pkg::OPC12_ORI:   r = a | zx;
            default:             r = a ^ zx;
        endcase
        issue({opc, imm12, rj, rd}, 1'b0, 7'd0, 1'b0, la_pkg::EXC_NONE, rd, r);
    endtask

    task automatic run_lu12i(input logic [4:0] rd, input logic [19:0] si20);
        issue({la_pkg::OPC_LU12I, si20, rd}, 1'b0, 7'd0, 1'b0, la_pkg::EXC_NONE, rd,
              {si20, 12'd0});
    endtask

    task automatic run_exception(input logic [31:0] word, input logic fexc,
                                 input logic [6:0] fcause, input logic [6:0] cause);
        issue(word, fexc, fcause, 1'b1, cause, 5'd0, 32'd0);
    endtask

    task automatic drain();
        int n;
        @(posedge clk);
        valid     <= 1'b0;
        fetch_exc <= 1'b0;
        n = 0;
        while (q_pc.size() != 0) begin
            if (n == 10) begin
                report_problem("timeout waiting for outstanding commits");
            end else begin
                @(posedge clk);
                n++;
            end
        end
    endtask

    initial begin
        logic [2:0]  s;
        logic [16:0] opc3;
        logic [9:0]  opc12;
        clk         = 1'b0;
        rst         = 1'b1;
        pc          = 32'd0;
        inst        = 32'd0;
        valid       = 1'b0;
        fetch_exc   = 1'b0;
        fetch_cause = 7'd0;
        lfsr        = 16'd93;
        next_pc     = 32'h1c00_0000;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = 32'd0;

        test_name = "reset";
        @(posedge clk);
        @(negedge clk);
        check_idle();
        @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(negedge clk);
        check_idle(); // idle word 0 decodes as INE and has passed execute
        for (int k = 1; k < 32; k++)
            run_3r(la_pkg::OPC3R_ADD, 5'(k), 5'(k), 5'(k)); // all zero after reset
        drain();

        test_name = "ops_3r";
        for (int k = 1; k < 32; k++) begin
            run_lu12i(5'(k), 20'(rand_bits(20)));
            run_i12(la_pkg::OPC12_ORI, 5'(k), 5'(k), 12'(rand_bits(12)));
        end
        for (int n = 0; n < 80; n++) begin
            s = 3'(rand_bits(3) % 7);
            case (s)
                3'd0:    opc3 = la_pkg::OPC3R_ADD;
                3'd1:    opc3 = la_pkg::OPC3R_SUB;
                3'd2:    opc3 = la_pkg::OPC3R_SLT;
                3'd3:    opc3 = la_pkg::OPC3R_SLTU;
                3'd4:    opc3 = la_pkg::OPC3R_AND;
                3'd5:    opc3 = la_pkg::OPC3R_OR;
                default: opc3 = la_pkg::OPC3R_XOR;
            endcase
            run_3r(opc3, 5'(rand_bits(5)), 5'(rand_bits(5)), 5'(rand_bits(5)));
        end
        drain();

        test_name = "immediates";
        run_i12(la_pkg::OPC12_ADDI, 5'd1, 5'd0, 12'h800); // most negative si12
        run_i12(la_pkg::OPC12_ANDI, 5'd2, 5'd1, 12'hfff);
        run_i12(la_pkg::OPC12_SLTUI, 5'd3, 5'd2, 12'hfff);
        run_lu12i(5'd4, 20'hfffff);
        for (int n = 0; n < 60; n++) begin
            s = 3'(rand_bits(3) % 6);
            case (s)
                3'd0:    opc12 = la_pkg::OPC12_ADDI;
                3'd1:    opc12 = la_pkg::OPC12_SLTI;
                3'd2:    opc12 = la_pkg::OPC12_SLTUI;
                3'd3:    opc12 = la_pkg::OPC12_ANDI;
                3'd4:    opc12 = la_pkg::OPC12_ORI;
                default: opc12 = la_pkg::OPC12_XORI;
            endcase
            run_i12(opc12, 5'(rand_bits(5)), 5'(rand_bits(5)), 12'(rand_bits(12)));
            if (n % 8 == 0)
                run_lu12i(5'(rand_bits(5)), 20'(rand_bits(20)));
        end
        drain();

        test_name = "exceptions";
        run_exception({la_pkg::OPC3R_SYSCALL, 15'(rand_bits(15))}, 1'b0, 7'h08, la_pkg::EXC_SYS);
        run_exception({la_pkg::OPC3R_BREAK, 15'(rand_bits(15))}, 1'b0, 7'h01, la_pkg::EXC_BRK);
        run_exception(32'hffff_ffff, 1'b0, 7'h3f, la_pkg::EXC_INE);
        run_exception(32'h0000_0000, 1'b0, 7'd0, la_pkg::EXC_INE);
        run_exception({la_pkg::OPC3R_ADD, 5'd1, 5'd2, 5'd3}, 1'b1, 7'h08, 7'h08);
        run_exception(32'hffff_ffff, 1'b1, 7'h01, 7'h01); // fetch cause wins over INE
        run_3r(la_pkg::OPC3R_OR, 5'd5, 5'd3, 5'd0); // r3 untouched by the faulting add
        drain();

        test_name = "r0_bypass";
        run_3r(la_pkg::OPC3R_ADD, 5'd0, 5'd1, 5'd2);
        run_i12(la_pkg::OPC12_ORI, 5'd0, 5'd0, 12'h5a5);
        run_3r(la_pkg::OPC3R_OR, 5'd6, 5'd0, 5'd0);
        run_lu12i(5'd7, 20'h12345);
        @(posedge clk);
        valid <= 1'b0;
        run_i12(la_pkg::OPC12_ORI, 5'd8, 5'd7, 12'h678); // two cycles after its writer
        run_3r(la_pkg::OPC3R_SUB, 5'd9, 5'd8, 5'd7);
        drain();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
